/* dv/tb_usb_ep_tasks.svh */
`ifndef TB_USB_EP_TASKS_SVH
`define TB_USB_EP_TASKS_SVH

// ------------------------------
// Packet helpers
// ------------------------------

// Reflected CRC-16 stepped one data bit at a time
function automatic logic [15:0] crc16_byte(input logic [15:0] crc, input logic [7:0] b);
	logic [15:0] c;
	logic        fb;
	int          i;
	c = crc;
	for (i = 0; i < 8; i++) begin
		fb = c[0] ^ b[i];
		c  = c >> 1;
		if (fb) begin
			c = c ^ CRC16_POLY;
		end
	end
	return c;
endfunction

// Random payload with the inverted CRC appended low byte first
task automatic send_packet(input int slot, input int len, input bit corrupt);
	logic [7:0]  frame [0:MAX_FRAME-1];
	logic [15:0] crc;
	int          i;
	crc = CRC16_INIT;
	for (i = 0; i < len; i++) begin
		frame[i] = 8'(rand_bits(8));
		crc      = crc16_byte(crc, frame[i]);
	end
	crc            = ~crc;
	frame[len]     = crc[7:0];
	frame[len + 1] = crc[15:8];
	// One payload byte may be damaged
	if (corrupt) begin
		i        = int'(rand_bits(6)) % len;
		frame[i] = frame[i] ^ 8'h10;
	end
	// A good frame ends at the residual and a damaged one does not
	crc = CRC16_INIT;
	for (i = 0; i < len + 2; i++) begin
		crc = crc16_byte(crc, frame[i]);
	end
	assert ((crc == CRC16_RESIDUAL) == !corrupt) else begin
		$display("Generated frame CRC disagrees with the residual rule");
		other_errs++;
	end
	sent_crc_ok[slot] = !corrupt;
	sent_len[slot]    = len;
	for (i = 0; i < len; i++) begin
		sent[slot][i] = frame[i];
	end
	@(posedge rd_clk);
	rx_sop <= 1'b1;
	for (i = 0; i < len + 2; i++) begin
		@(posedge rd_clk);
		rx_sop  <= 1'b0;
		rx_stb  <= 1'b1;
		rx_data <= frame[i];
	end
	@(posedge rd_clk);
	rx_stb <= 1'b0;
	rx_eop <= 1'b1;
	@(posedge rd_clk);
	rx_eop <= 1'b0;
endtask

task automatic wait_avail();
	int n;
	n = 0;
	while ((pkt_avail !== 1'b1) && (n < TIMEOUT)) begin
		@(negedge rd_clk);
		n++;
	end
	assert (pkt_avail === 1'b1) else begin
		$display("Timed out after %0d cycles waiting for a packet to become available", n);
		other_errs++;
	end
endtask

task automatic wait_nak(input int start_cnt);
	int n;
	n = 0;
	while ((nak_cnt == start_cnt) && (n < TIMEOUT)) begin
		@(negedge rd_clk);
		n++;
	end
	assert (nak_cnt != start_cnt) else begin
		$display("Timed out after %0d cycles waiting for a nak pulse", n);
		other_errs++;
	end
endtask

// Status of the head packet and every payload word
task automatic check_head(input int slot);
	logic [31:0] exp;
	logic [31:0] mask;
	int          w;
	int          b;
	int          idx;
	@(negedge rd_clk);
	check_val("pkt_avail", 32'd1, 32'(pkt_avail));
	check_val("pkt_len", 32'(sent_len[slot]), 32'(pkt_len));
	check_val("pkt_crc_ok", 32'(sent_crc_ok[slot]), 32'(pkt_crc_ok));
	for (w = 0; w < (sent_len[slot] + 3) / 4; w++) begin
		@(posedge rd_clk);
		bus_rd   <= 1'b1;
		bus_addr <= (AWIDTH-2)'(w);
		@(posedge rd_clk);
		bus_rd <= 1'b0;
		@(negedge rd_clk);
		exp  = '0;
		mask = '0;
		for (b = 0; b < 4; b++) begin
			idx = 4 * w + b;
			if (idx < sent_len[slot]) begin
				exp[8*b +: 8]  = sent[slot][idx];
				mask[8*b +: 8] = 8'hff;
			end
		end
		check_val("bus_rdata", exp, bus_rdata & mask);
	end
endtask

task automatic release_head(input logic exp_avail);
	@(posedge rd_clk);
	bus_release <= 1'b1;
	@(posedge rd_clk);
	bus_release <= 1'b0;
	@(negedge rd_clk);
	check_val("pkt_avail", 32'(exp_avail), 32'(pkt_avail));
endtask

// ------------------------------
// Directed tests
// ------------------------------

task automatic test_reset();
	@(negedge rd_clk);
	check_val("pkt_avail", 32'd0, 32'(pkt_avail));
	check_val("nak", 32'd0, 32'(nak));
endtask

task automatic test_good_packet();
	int len;
	len = int'(rand_bits(6) % 32'd62) + 1;
	send_packet(0, len, 1'b0);
	wait_avail();
	check_head(0);
	release_head(1'b0);
endtask

task automatic test_bad_crc();
	send_packet(0, 20, 1'b1);
	wait_avail();
	check_head(0);
	release_head(1'b0);
endtask

task automatic test_back_to_back();
	send_packet(0, int'(rand_bits(6) % 32'd62) + 1, 1'b0);
	send_packet(1, int'(rand_bits(6) % 32'd62) + 1, 1'b0);
	wait_avail();
	check_head(0);
	release_head(1'b1);
	check_head(1);
	release_head(1'b0);
endtask

task automatic test_nak_when_full();
	int start_cnt;
	send_packet(0, 17, 1'b0);
	send_packet(1, 33, 1'b0);
	wait_avail();
	start_cnt = nak_cnt;
	send_packet(2, 9, 1'b0);
	wait_nak(start_cnt);
	// Stored packets untouched by the refused one
	check_head(0);
	release_head(1'b1);
	check_head(1);
	release_head(1'b0);
endtask

task automatic test_overflow();
	int i;
	// Payload plus CRC is one byte more than a buffer holds
	send_packet(0, BUF_BYTES - 1, 1'b0);
	for (i = 0; i < 16; i++) begin
		@(negedge rd_clk);
		check_val("pkt_avail", 32'd0, 32'(pkt_avail));
	end
	send_packet(0, 40, 1'b0);
	wait_avail();
	check_head(0);
	release_head(1'b0);
endtask

`endif

/* dv/tb_usb_ep_out.sv */
module tb_usb_ep_out
	import usb_ep_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int AWIDTH    = 6;
	localparam int BUF_BYTES = 2 ** AWIDTH;
	localparam int MAX_FRAME = 2 * BUF_BYTES;
	localparam int NUM_SLOTS = 3;
	localparam int TIMEOUT   = 200;

	logic              rd_clk = 1'b0;
	logic              arst_n;
	logic              rx_sop;
	logic              rx_stb;
	logic              rx_eop;
	logic [7:0]        rx_data;
	logic              nak;
	logic              pkt_avail;
	logic [AWIDTH:0]   pkt_len;
	logic              pkt_crc_ok;
	logic              bus_rd;
	logic [AWIDTH-3:0] bus_addr;
	logic [31:0]       bus_rdata;
	logic              bus_release;

	// Expected contents of each packet sent
	logic [7:0] sent [0:NUM_SLOTS-1][0:MAX_FRAME-1];
	int         sent_len [0:NUM_SLOTS-1];
	logic       sent_crc_ok [0:NUM_SLOTS-1];

	int          val_errs = 0;
	int          other_errs = 0;
	int          nak_cnt = 0;
	logic [31:0] lfsr = 32'hea2d_20fa;

	usb_ep_out #(
		.AWIDTH (AWIDTH)
	) i_usb_ep_out (
		.rd_clk      (rd_clk),
		.arst_n      (arst_n),
		.rx_sop      (rx_sop),
		.rx_stb      (rx_stb),
		.rx_eop      (rx_eop),
		.rx_data     (rx_data),
		.nak         (nak),
		.pkt_avail   (pkt_avail),
		.pkt_len     (pkt_len),
		.pkt_crc_ok  (pkt_crc_ok),
		.bus_rd      (bus_rd),
		.bus_addr    (bus_addr),
		.bus_rdata   (bus_rdata),
		.bus_release (bus_release)
	);

	always #20 rd_clk = ~rd_clk;

	// Count refusals, sampled away from the active edge
	always @(negedge rd_clk) begin
		if (arst_n === 1'b1 && nak === 1'b1) begin
			nak_cnt++;
		end
	end

	// ------------------------------
	// Random bits, taps 32 22 2 1
	// ------------------------------

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		logic        fb;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			r    = {r[30:0], fb};
		end
		return r;
	endfunction

	task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (act === exp) else begin
			$display("ERR t=%0t %s expected %h actual %h", $time, name, exp, act);
			val_errs++;
		end
	endtask

	`include "tb_usb_ep_tasks.svh"

	initial begin
		arst_n      = 1'b0;
		rx_sop      = 1'b0;
		rx_stb      = 1'b0;
		rx_eop      = 1'b0;
		rx_data     = 8'h00;
		bus_rd      = 1'b0;
		bus_addr    = '0;
		bus_release = 1'b0;
		repeat (4) @(posedge rd_clk);
		arst_n <= 1'b1;

		test_reset();
		test_good_packet();
		test_bad_crc();
		test_back_to_back();
		test_nak_when_full();
		test_overflow();

		// Only the full-queue test may refuse a packet
		check_val("nak pulse count", 32'd1, nak_cnt);

		$display("Errors: %0d value mismatches, %0d other failures", val_errs, other_errs);
		if (val_errs + other_errs == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

/* hw/usb_bus_rd.sv */
module usb_bus_rd
	import usb_ep_pkg::*;
#(
	parameter int AWIDTH = 6
) (
	input  logic                rd_clk,
	input  logic                arst_n,

	// From the receiver
	input  logic                commit,
	input  logic [AWIDTH:0]     commit_len,
	input  logic                commit_crc_ok,

	// CPU side
	input  logic                bus_rd,
	input  logic [AWIDTH-3:0]   bus_addr,
	input  logic                bus_release,

	// Buffer read ports
	input  logic [31:0]         rd_data_a,
	input  logic [31:0]         rd_data_b,
	output logic [AWIDTH-3:0]   rd_addr,
	output logic                rd_en_a,
	output logic                rd_en_b,

	output logic [NUM_BUFS-1:0] buf_free,
	output logic                pkt_avail,
	output logic [AWIDTH:0]     pkt_len,
	output logic                pkt_crc_ok,
	output logic [31:0]         bus_rdata
);

	localparam int IDXW = $clog2(NUM_BUFS);

	logic [NUM_BUFS-1:0] full;
	logic [AWIDTH:0]     len_q [NUM_BUFS];
	logic [NUM_BUFS-1:0] crc_q;
	logic [IDXW-1:0]     wr_idx;
	logic [IDXW-1:0]     head_idx;
	logic [IDXW-1:0]     rd_sel;

	// ------------------------------
	// Queue bookkeeping
	// ------------------------------

	always_ff @(posedge rd_clk or negedge arst_n) begin
		if (!arst_n) begin
			full     <= '0;
			wr_idx   <= '0;
			head_idx <= '0;
		end else begin
			if (commit) begin
				full[wr_idx] <= 1'b1;
				wr_idx       <= (wr_idx == IDXW'(NUM_BUFS - 1)) ? '0 : wr_idx + 1'b1;
			end
			if (bus_release) begin
				full[head_idx] <= 1'b0;
				head_idx       <= (head_idx == IDXW'(NUM_BUFS - 1)) ? '0 : head_idx + 1'b1;
			end
		end
	end

	// Per-buffer packet info, only meaningful while full
	always_ff @(posedge rd_clk) begin
		if (commit) begin
			len_q[wr_idx] <= commit_len;
			crc_q[wr_idx] <= commit_crc_ok;
		end
	end

	assign buf_free   = ~full;
	assign pkt_avail  = full[head_idx];
	assign pkt_len    = len_q[head_idx];
	assign pkt_crc_ok = crc_q[head_idx];

	// ------------------------------
	// Word reads
	// ------------------------------

	assign rd_addr = bus_addr;
	assign rd_en_a = bus_rd && (head_idx == IDXW'(0));
	assign rd_en_b = bus_rd && (head_idx == IDXW'(1));

	// Which buffer answers, kept past a release
	always_ff @(posedge rd_clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_sel <= '0;
		end else if (bus_rd) begin
			rd_sel <= head_idx;
		end
	end

	assign bus_rdata = (rd_sel == IDXW'(1)) ? rd_data_b : rd_data_a;

	a_bus_needs_pkt: assert property (
		@(posedge rd_clk) disable iff (!arst_n)
		(bus_rd || bus_release) |-> pkt_avail
	);

endmodule

/* hw/usb_crc16.sv */
module usb_crc16
	import usb_ep_pkg::*;
(
	input  logic        rd_clk,
	input  logic        arst_n,
	input  logic        crc_clear,
	input  logic        crc_stb,
	input  logic [7:0]  crc_data,
	output logic        crc_ok
);

	logic [15:0] crc;

	// One byte through the reflected LFSR, bit 0 first
	function automatic logic [15:0] crc_step(
		input logic [15:0] crc_in,
		input logic [7:0]  data
	);
		logic [15:0] c;
		c = crc_in ^ {8'h00, data};
		for (int i = 0; i < 8; i++) begin
			if (c[0]) begin
				c = (c >> 1) ^ CRC16_POLY;
			end else begin
				c = c >> 1;
			end
		end
		return c;
	endfunction

	always_ff @(posedge rd_clk or negedge arst_n) begin
		if (!arst_n) begin
			crc <= CRC16_INIT;
		end else if (crc_clear) begin
			crc <= CRC16_INIT;
		end else if (crc_stb) begin
			crc <= crc_step(crc, crc_data);
		end
	end

	// Good once the appended CRC bytes have been folded in
	assign crc_ok = (crc == CRC16_RESIDUAL);

endmodule

/* hw/usb_ep_buf.sv */
module usb_ep_buf #(
	parameter int AWIDTH = 6
) (
	input  logic                rd_clk,
	input  logic                arst_n,

	// Byte write port
	input  logic [AWIDTH-1:0]   wr_addr,
	input  logic [7:0]          wr_data,
	input  logic                wr_en,

	// Word read port
	input  logic [AWIDTH-3:0]   rd_addr,
	input  logic                rd_en,
	output logic [31:0]         rd_data
);

	localparam int NUM_WORDS = 2 ** (AWIDTH - 2);

	logic [31:0] mem [0:NUM_WORDS-1];

	logic [AWIDTH-3:0] wr_word;
	logic [1:0]        wr_lane;

	// Byte i lives in word i/4, lane i%4
	assign wr_word = wr_addr[AWIDTH-1:2];
	assign wr_lane = wr_addr[1:0];

	// ------------------------------
	// Write side
	// ------------------------------

	always_ff @(posedge rd_clk) begin
		if (wr_en) begin
			mem[wr_word][8*wr_lane +: 8] <= wr_data;
		end
	end

	// ------------------------------
	// Read side
	// ------------------------------

	// Word held until the next enabled read
	always_ff @(posedge rd_clk) begin
		if (rd_en) begin
			rd_data <= mem[rd_addr];
		end
	end

	// Fill side only writes free buffers, bus side only reads the head one
	a_no_rw_collision: assert property (
		@(posedge rd_clk) disable iff (!arst_n)
		!(wr_en && rd_en && (wr_word == rd_addr))
	);

endmodule

/* hw/usb_ep_out.sv */
module usb_ep_out
	import usb_ep_pkg::*;
#(
	parameter int AWIDTH = 6
) (
	input  logic              rd_clk,
	input  logic              arst_n,

	// Packet decoder side
	input  logic              rx_sop,
	input  logic              rx_stb,
	input  logic              rx_eop,
	input  logic [7:0]        rx_data,
	output logic              nak,

	// CPU side
	output logic              pkt_avail,
	output logic [AWIDTH:0]   pkt_len,
	output logic              pkt_crc_ok,
	input  logic              bus_rd,
	input  logic [AWIDTH-3:0] bus_addr,
	output logic [31:0]       bus_rdata,
	input  logic              bus_release
);

	logic [AWIDTH-1:0]   wr_addr;
	logic [7:0]          wr_data;
	logic                wr_en_a;
	logic                wr_en_b;
	logic                commit;
	logic [AWIDTH:0]     commit_len;
	logic                commit_crc_ok;
	logic [NUM_BUFS-1:0] buf_free;
	logic [AWIDTH-3:0]   rd_addr;
	logic                rd_en_a;
	logic                rd_en_b;
	logic [31:0]         rd_data_a;
	logic [31:0]         rd_data_b;

	// ------------------------------
	// Receive path
	// ------------------------------

	usb_rx_fill #(
		.AWIDTH (AWIDTH)
	) i_usb_rx_fill (
		.rd_clk        (rd_clk),
		.arst_n        (arst_n),
		.rx_sop        (rx_sop),
		.rx_stb        (rx_stb),
		.rx_eop        (rx_eop),
		.rx_data       (rx_data),
		.buf_free      (buf_free),
		.wr_addr       (wr_addr),
		.wr_data       (wr_data),
		.wr_en_a       (wr_en_a),
		.wr_en_b       (wr_en_b),
		.commit        (commit),
		.commit_len    (commit_len),
		.commit_crc_ok (commit_crc_ok),
		.nak           (nak)
	);

	// Ping-pong pair
	usb_ep_buf #(
		.AWIDTH (AWIDTH)
	) i_buf_a (
		.rd_clk  (rd_clk),
		.arst_n  (arst_n),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en_a),
		.rd_addr (rd_addr),
		.rd_en   (rd_en_a),
		.rd_data (rd_data_a)
	);

	usb_ep_buf #(
		.AWIDTH (AWIDTH)
	) i_buf_b (
		.rd_clk  (rd_clk),
		.arst_n  (arst_n),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.wr_en   (wr_en_b),
		.rd_addr (rd_addr),
		.rd_en   (rd_en_b),
		.rd_data (rd_data_b)
	);

	// ------------------------------
	// Bus side
	// ------------------------------

	usb_bus_rd #(
		.AWIDTH (AWIDTH)
	) i_usb_bus_rd (
		.rd_clk        (rd_clk),
		.arst_n        (arst_n),
		.commit        (commit),
		.commit_len    (commit_len),
		.commit_crc_ok (commit_crc_ok),
		.bus_rd        (bus_rd),
		.bus_addr      (bus_addr),
		.bus_release   (bus_release),
		.rd_data_a     (rd_data_a),
		.rd_data_b     (rd_data_b),
		.rd_addr       (rd_addr),
		.rd_en_a       (rd_en_a),
		.rd_en_b       (rd_en_b),
		.buf_free      (buf_free),
		.pkt_avail     (pkt_avail),
		.pkt_len       (pkt_len),
		.pkt_crc_ok    (pkt_crc_ok),
		.bus_rdata     (bus_rdata)
	);

endmodule

/* hw/usb_ep_pkg.sv */
package usb_ep_pkg;

	// ------------------------------
	// Receiver FSM
	// ------------------------------

	// Idle between packets, filling a buffer, or discarding until end of packet
	typedef enum logic [1:0] {
		FILL_IDLE = 2'd0,
		FILL_DATA = 2'd1,
		FILL_DROP = 2'd2
	} fill_state_t;

	// ------------------------------
	// Data CRC-16
	// ------------------------------

	// Reflected form of x^16 + x^15 + x^2 + 1
	localparam logic [15:0] CRC16_POLY = 16'hA001;

	// Register preset before the first byte
	localparam logic [15:0] CRC16_INIT = 16'hFFFF;

	// Remainder after payload plus both CRC bytes of a good packet
	localparam logic [15:0] CRC16_RESIDUAL = 16'hB001;

	// ------------------------------
	// Buffering
	// ------------------------------

	// Ping-pong pair
	localparam int NUM_BUFS = 2;

endpackage

/* hw/usb_rx_fill.sv */
module usb_rx_fill
	import usb_ep_pkg::*;
#(
	parameter int AWIDTH = 6
) (
	input  logic                rd_clk,
	input  logic                arst_n,

	// Byte stream from the packet decoder
	input  logic                rx_sop,
	input  logic                rx_stb,
	input  logic                rx_eop,
	input  logic [7:0]          rx_data,

	// Space reported by the bus side
	input  logic [NUM_BUFS-1:0] buf_free,

	// Shared write port, per-buffer enables
	output logic [AWIDTH-1:0]   wr_addr,
	output logic [7:0]          wr_data,
	output logic                wr_en_a,
	output logic                wr_en_b,

	// Packet hand-off
	output logic                commit,
	output logic [AWIDTH:0]     commit_len,
	output logic                commit_crc_ok,
	output logic                nak
);

	localparam int IDXW = $clog2(NUM_BUFS);

	fill_state_t     state;
	logic [IDXW-1:0] fill_idx;
	logic [AWIDTH:0] cnt;
	logic            cnt_full;
	logic            byte_wr;
	logic            crc_ok;

	// Every address already used, next byte overflows
	assign cnt_full = cnt[AWIDTH];

	assign byte_wr = (state == FILL_DATA) && rx_stb && !cnt_full;

	assign wr_addr = cnt[AWIDTH-1:0];
	assign wr_data = rx_data;
	assign wr_en_a = byte_wr && (fill_idx == IDXW'(0));
	assign wr_en_b = byte_wr && (fill_idx == IDXW'(1));

	// ------------------------------
	// Running CRC
	// ------------------------------

	usb_crc16 i_crc (
		.rd_clk    (rd_clk),
		.arst_n    (arst_n),
		.crc_clear (rx_sop),
		.crc_stb   (byte_wr),
		.crc_data  (rx_data),
		.crc_ok    (crc_ok)
	);

	// ------------------------------
	// Fill FSM
	// ------------------------------

	always_ff @(posedge rd_clk or negedge arst_n) begin
		if (!arst_n) begin
			state    <= FILL_IDLE;
			fill_idx <= '0;
			cnt      <= '0;
			commit   <= 1'b0;
			nak      <= 1'b0;
		end else begin
			commit <= 1'b0;
			nak    <= 1'b0;
			case (state)
				FILL_IDLE: begin
					if (rx_sop) begin
						cnt <= '0;
						if (buf_free[fill_idx]) begin
							state <= FILL_DATA;
						end else begin
							// No room, refuse the whole packet
							nak   <= 1'b1;
							state <= FILL_DROP;
						end
					end
				end
				FILL_DATA: begin
					if (rx_stb) begin
						if (cnt_full) begin
							state <= FILL_DROP;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end else if (rx_eop) begin
						state <= FILL_IDLE;
						// Too short to carry a CRC, discard quietly
						if (cnt >= (AWIDTH+1)'(2)) begin
							commit   <= 1'b1;
							fill_idx <= (fill_idx == IDXW'(NUM_BUFS - 1)) ? '0 : fill_idx + 1'b1;
						end
					end
				end
				FILL_DROP: begin
					if (rx_eop) begin
						state <= FILL_IDLE;
					end
				end
				default: begin
					state <= FILL_IDLE;
				end
			endcase
		end
	end

	// Length without the CRC bytes, CRC verdict at end of packet
	always_ff @(posedge rd_clk) begin
		if ((state == FILL_DATA) && rx_eop) begin
			commit_len    <= cnt - (AWIDTH+1)'(2);
			commit_crc_ok <= crc_ok;
		end
	end

	// ------------------------------
	// Checks
	// ------------------------------

	a_no_stb_idle: assert property (
		@(posedge rd_clk) disable iff (!arst_n)
		!(rx_stb && (state == FILL_IDLE))
	);

	// Index has already moved on when commit fires
	a_commit_free: assert property (
		@(posedge rd_clk) disable iff (!arst_n)
		commit |-> buf_free[$past(fill_idx)]
	);

endmodule

/* list.f */
+incdir+dv
hw/usb_ep_pkg.sv
hw/usb_ep_buf.sv
hw/usb_crc16.sv
hw/usb_rx_fill.sv
hw/usb_bus_rd.sv
hw/usb_ep_out.sv
dv/tb_usb_ep_out.sv
